// File: source/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// frame format, fixed at build time

`define UART_DATA_WIDTH 8 // data bits per frame

`define UART_PARITY_EN 1'b1 // 1 adds a parity bit after the data

`define UART_PARITY_ODD 1'b0 // 0 even, 1 odd

`define UART_CLKS_PER_BIT 8 // clock cycles per bit period

// depth of the rx pin synchronizer
`define UART_SYNC_STAGES 3

`endif

// File: source/uart_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t; // one data word

	typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_t; // cycles within a bit

	typedef logic [$clog2(`UART_DATA_WIDTH)-1:0] bit_idx_t; // data bit position

	// received word plus line status
	typedef struct packed {
		uart_data_t data;
		logic parity_error; // parity bit mismatch
		logic frame_error; // stop bit sampled low
	} rx_result_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

endpackage

`default_nettype wire

// File: source/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_baud_gen
	import uart_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	output logic o_tick
);

	localparam baud_cnt_t CNT_LAST = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

	baud_cnt_t cnt_q; // free-running bit phase

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt_q <= '0;
		end else if (cnt_q == CNT_LAST) begin
			cnt_q <= '0; // wrap
		end else begin
			cnt_q <= cnt_q + baud_cnt_t'(1);
		end
	end

	// one cycle per bit period, at the wrap
	assign o_tick = (cnt_q == CNT_LAST);

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_tx
	import uart_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_tick,
	input wire logic i_tx_en,
	input wire uart_data_t i_tx_data,
	output logic o_tx_busy,
	output logic o_serial_out
);

	localparam bit_idx_t IDX_LAST = bit_idx_t'(`UART_DATA_WIDTH - 1);

	tx_state_e state_q;
	bit_idx_t bit_idx_q; // data bit now on the line
	logic busy_q;
	logic serial_q; // registered line driver
	uart_data_t shift_q; // piso, lsb goes out first
	logic parity_q;
	logic tx_accept;
	logic tx_shift;

	assign tx_accept = i_tx_en && !busy_q; // requests ignored while busy

	// next data bit leaves the register on start and data ticks
	assign tx_shift = i_tick && ((state_q == TX_START) || (state_q == TX_DATA));

	always_ff @(posedge clk) begin
		if (tx_accept) begin
			shift_q <= i_tx_data;
			parity_q <= (^i_tx_data) ^ `UART_PARITY_ODD;
		end else if (tx_shift) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= TX_IDLE;
			bit_idx_q <= '0;
			busy_q <= 1'b0;
			serial_q <= 1'b1; // line idles high
		end else begin
			case (state_q)
				TX_IDLE: begin
					if (tx_accept) begin
						busy_q <= 1'b1; // wait here for the next tick
					end else if (busy_q && i_tick) begin
						serial_q <= 1'b0; // start bit
						state_q <= TX_START;
					end
				end
				TX_START: begin
					if (i_tick) begin
						serial_q <= shift_q[0];
						bit_idx_q <= '0;
						state_q <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (i_tick) begin
						if (bit_idx_q == IDX_LAST) begin
							if (`UART_PARITY_EN) begin
								serial_q <= parity_q;
								state_q <= TX_PARITY;
							end else begin
								serial_q <= 1'b1; // stop bit
								state_q <= TX_STOP;
							end
						end else begin
							serial_q <= shift_q[0];
							bit_idx_q <= bit_idx_q + bit_idx_t'(1);
						end
					end
				end
				TX_PARITY: begin
					if (i_tick) begin
						serial_q <= 1'b1; // stop bit
						state_q <= TX_STOP;
					end
				end
				TX_STOP: begin
					if (i_tick) begin
						busy_q <= 1'b0; // drops one cycle after the final tick
						state_q <= TX_IDLE;
					end
				end
				default: begin
					state_q <= TX_IDLE;
				end
			endcase
		end
	end

	assign o_tx_busy = busy_q;
	assign o_serial_out = serial_q;

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_rx
	import uart_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_serial_in,
	output logic o_rx_valid,
	output rx_result_t o_rx_result
);

	localparam baud_cnt_t CNT_HALF = baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);
	localparam baud_cnt_t CNT_FULL = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
	localparam bit_idx_t IDX_LAST = bit_idx_t'(`UART_DATA_WIDTH - 1);

	logic [`UART_SYNC_STAGES-1:0] sync_q; // pin synchronizer, [0] is first
	logic line_prev_q;
	logic line_now;
	logic start_edge;

	rx_state_e state_q;
	baud_cnt_t cnt_q; // restarted on every start edge
	bit_idx_t bit_idx_q;
	uart_data_t shift_q;
	logic parity_err_q;
	logic valid_q;
	rx_result_t result_q;
	logic half_done;
	logic bit_done;

	assign line_now = sync_q[`UART_SYNC_STAGES-1];
	assign start_edge = line_prev_q && !line_now; // high to low at sync output
	assign half_done = (cnt_q == CNT_HALF);
	assign bit_done = (cnt_q == CNT_FULL);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1; // idle line
			line_prev_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial_in};
			line_prev_q <= line_now;
		end
	end

	// data and parity status, cleared when a start bit is confirmed
	always_ff @(posedge clk) begin
		if ((state_q == RX_START) && half_done) begin
			parity_err_q <= 1'b0;
		end
		if ((state_q == RX_DATA) && bit_done) begin
			shift_q <= {line_now, shift_q[`UART_DATA_WIDTH-1:1]}; // lsb first
		end
		if ((state_q == RX_PARITY) && bit_done) begin
			parity_err_q <= line_now ^ (^shift_q) ^ `UART_PARITY_ODD;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= RX_IDLE;
			cnt_q <= '0;
			bit_idx_q <= '0;
			valid_q <= 1'b0;
			result_q <= '0;
		end else begin
			valid_q <= 1'b0; // single-cycle pulse
			case (state_q)
				RX_IDLE: begin
					if (start_edge) begin
						cnt_q <= '0;
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (half_done) begin
						cnt_q <= '0;
						bit_idx_q <= '0;
						// a high line at mid start bit was a glitch
						state_q <= line_now ? RX_IDLE : RX_DATA;
					end else begin
						cnt_q <= cnt_q + baud_cnt_t'(1);
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						cnt_q <= '0;
						if (bit_idx_q == IDX_LAST) begin
							state_q <= `UART_PARITY_EN ? RX_PARITY : RX_STOP;
						end else begin
							bit_idx_q <= bit_idx_q + bit_idx_t'(1);
						end
					end else begin
						cnt_q <= cnt_q + baud_cnt_t'(1);
					end
				end
				RX_PARITY: begin
					if (bit_done) begin
						cnt_q <= '0;
						state_q <= RX_STOP;
					end else begin
						cnt_q <= cnt_q + baud_cnt_t'(1);
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						valid_q <= 1'b1;
						result_q.data <= shift_q;
						result_q.parity_error <= parity_err_q;
						result_q.frame_error <= !line_now; // stop must be high
						state_q <= RX_IDLE;
					end else begin
						cnt_q <= cnt_q + baud_cnt_t'(1);
					end
				end
				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

	assign o_rx_valid = valid_q;
	assign o_rx_result = result_q; // held until the next frame

endmodule

`default_nettype wire

// File: source/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_top
	import uart_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic i_tx_en,
	input wire uart_data_t i_tx_data,
	output logic o_tx_busy,
	output logic o_serial_out,
	input wire logic i_serial_in,
	output logic o_rx_valid,
	output rx_result_t o_rx_result
);

	logic baud_tick; // tx bit pacing only

	uart_baud_gen u_baud_gen (
		.clk (clk),
		.reset (reset),
		.o_tick (baud_tick)
	);

	uart_tx u_tx (
		.clk (clk),
		.reset (reset),
		.i_tick (baud_tick),
		.i_tx_en (i_tx_en),
		.i_tx_data (i_tx_data),
		.o_tx_busy (o_tx_busy),
		.o_serial_out (o_serial_out)
	);

	// rx keeps its own bit timing from the start edge
	uart_rx u_rx (
		.clk (clk),
		.reset (reset),
		.i_serial_in (i_serial_in),
		.o_rx_valid (o_rx_valid),
		.o_rx_result (o_rx_result)
	);

endmodule

`default_nettype wire

// File: sim/tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module tb_uart_top
	import uart_pkg::*;
;

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int DW = `UART_DATA_WIDTH;
	localparam int PAR_BITS = `UART_PARITY_EN ? 1 : 0;
	localparam int FRAME_BITS = DW + 2 + PAR_BITS; // start, data, parity, stop
	localparam int FRAME_CYCLES = FRAME_BITS * CLKS;
	localparam int NUM_LOOP = 200;
	localparam int NUM_INJ = 48;
	localparam int NUM_GLITCH = 8;
	localparam int MAX_GAP = 15;
	localparam int QUIET_CYCLES = 80; // idle line after a glitch
	localparam int DRAIN_LIMIT = 200;
	localparam int TIMEOUT_CYCLES =
		(NUM_LOOP + NUM_INJ + NUM_GLITCH + 1) * (100 + MAX_GAP + 2) + 1000;

	logic clk;
	logic reset;
	logic i_tx_en;
	uart_data_t i_tx_data;
	logic o_tx_busy;
	logic o_serial_out;
	logic serial_line;
	logic o_rx_valid;
	rx_result_t o_rx_result;

	logic loopback; // 1: rx pin follows tx pin
	logic inj_line; // line level from the frame driver
	logic [31:0] rng_state;
	rx_result_t exp_q[$];
	string test_name;
	int cycle_count = 0;

	assign serial_line = loopback ? o_serial_out : inj_line;

	uart_top UUT (
		.clk (clk),
		.reset (reset),
		.i_tx_en (i_tx_en),
		.i_tx_data (i_tx_data),
		.o_tx_busy (o_tx_busy),
		.o_serial_out (o_serial_out),
		.i_serial_in (serial_line),
		.o_rx_valid (o_rx_valid),
		.o_rx_result (o_rx_result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("Error: %s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		fail_run($sformatf("%s expected 0x%0h actual 0x%0h", name, exp_val, act_val));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return next_rand() % n;
	endfunction

	// bit that makes the count of ones even, flipped for odd parity
	function automatic logic model_parity(input uart_data_t d);
		int ones;
		ones = 0;
		for (int i = 0; i < DW; i++) begin
			if (d[i]) ones++;
		end
		return ((ones % 2) == 1) ^ `UART_PARITY_ODD;
	endfunction

	// line levels in send order, index 0 is the start bit
	function automatic logic [15:0] build_frame(input uart_data_t d);
		logic [15:0] f;
		f = '1;
		f[0] = 1'b0;
		for (int i = 0; i < DW; i++) begin
			f[i + 1] = d[i];
		end
		if (PAR_BITS != 0) f[DW + 1] = model_parity(d);
		return f;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	// one word through the transmitter, checking handshake and line shape
	task automatic send_word(input uart_data_t data, input bit poke_busy);
		logic [15:0] frame;
		rx_result_t exp_res;
		int cyc;
		int start_at;
		int k;
		frame = build_frame(data);
		exp_res.data = data;
		exp_res.parity_error = 1'b0;
		exp_res.frame_error = 1'b0;
		while (o_tx_busy) next_cycle();
		exp_q.push_back(exp_res);
		i_tx_en = 1'b1;
		i_tx_data = data;
		next_cycle(); // accepted on this edge
		assert (o_tx_busy == 1'b1)
		else report_mismatch($sformatf("%s busy after accept", test_name), 1,
			32'(o_tx_busy));
		if (poke_busy) begin
			i_tx_data = ~data; // must be ignored
		end else begin
			i_tx_en = 1'b0;
		end
		cyc = 0;
		start_at = -1;
		while (start_at < 0 || cyc < start_at + FRAME_CYCLES - 1) begin
			next_cycle();
			cyc++;
			if (cyc == 2) i_tx_en = 1'b0;
			assert (o_tx_busy) else fail_run($sformatf("%s: busy fell inside a frame", test_name));
			if (start_at < 0) begin
				if (!o_serial_out) begin
					start_at = cyc; // first falling edge
				end else begin
					assert (cyc < CLKS) else fail_run("no start bit within a bit period of accept");
				end
			end
			if (start_at >= 0 && ((cyc - start_at) % CLKS) == CLKS / 2) begin
				k = (cyc - start_at) / CLKS;
				assert (o_serial_out == frame[k])
				else report_mismatch($sformatf("%s frame bit %0d", test_name, k),
					32'(frame[k]), 32'(o_serial_out));
			end
		end
		next_cycle();
		assert (o_tx_busy == 1'b0)
		else report_mismatch($sformatf("%s busy after stop bit", test_name), 0,
			32'(o_tx_busy));
	endtask

	// drive a frame straight onto the rx pin
	task automatic inject_frame(input uart_data_t data, input bit bad_parity,
			input bit bad_stop);
		logic [15:0] frame;
		rx_result_t exp_res;
		frame = build_frame(data);
		if (bad_parity && PAR_BITS != 0) frame[DW + 1] = ~frame[DW + 1];
		if (bad_stop) frame[FRAME_BITS - 1] = 1'b0;
		exp_res.data = data;
		exp_res.parity_error = bad_parity && (PAR_BITS != 0);
		exp_res.frame_error = bad_stop;
		exp_q.push_back(exp_res);
		for (int k = 0; k < FRAME_BITS; k++) begin
			inj_line = frame[k];
			repeat (CLKS) next_cycle();
		end
		inj_line = 1'b1;
	endtask

	task automatic wait_rx_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
	endtask

	always @(negedge clk) begin : rx_check
		rx_result_t exp_res;
		if (!reset && o_rx_valid) begin
			assert (exp_q.size() > 0)
			else fail_run($sformatf("%s: o_rx_valid pulsed with no frame sent", test_name));
			exp_res = exp_q.pop_front();
			assert (o_rx_result == exp_res)
			else report_mismatch(test_name, 32'(exp_res), 32'(o_rx_result));
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("run timed out after %0d cycles", cycle_count));
		end
	end

	initial begin : main_flow
		uart_data_t data;
		logic [1:0] err_mode;
		int low_len;
		i_tx_en = 1'b0;
		i_tx_data = '0;
		inj_line = 1'b1;
		loopback = 1'b1;
		reset = 1'b1;
		rng_state = 32'h6a5e;
		test_name = "reset";
		repeat (4) @(posedge clk);
		#0.5;
		reset = 1'b0;

		for (int i = 0; i < 20; i++) begin
			assert (o_tx_busy == 1'b0)
			else report_mismatch("reset busy", 0, 32'(o_tx_busy));
			assert (o_serial_out == 1'b1)
			else report_mismatch("reset line", 1, 32'(o_serial_out));
			assert (o_rx_result == '0)
			else report_mismatch("reset result", 0, 32'(o_rx_result));
			next_cycle();
		end

		test_name = "loopback";
		for (int i = 0; i < NUM_LOOP; i++) begin
			data = uart_data_t'(next_rand());
			send_word(data, rand_below(4) == 0); // some requests poke while busy
			repeat (rand_below(MAX_GAP + 1)) next_cycle();
		end
		wait_rx_drain();
		assert (exp_q.size() == 0) else fail_run("loopback words were not all received");

		loopback = 1'b0;
		test_name = "injection";
		for (int i = 0; i < NUM_INJ; i++) begin
			data = uart_data_t'(next_rand());
			err_mode = 2'(rand_below(4));
			inject_frame(data, err_mode[0], err_mode[1]);
			repeat (2 + rand_below(MAX_GAP + 1)) next_cycle();
		end
		wait_rx_drain();

		test_name = "false start";
		for (int i = 0; i < NUM_GLITCH; i++) begin
			low_len = 1 + rand_below(3); // under half a bit
			inj_line = 1'b0;
			repeat (low_len) next_cycle();
			inj_line = 1'b1;
			repeat (QUIET_CYCLES + rand_below(MAX_GAP + 1)) next_cycle();
		end

		// receiver still takes a clean frame
		test_name = "after false start";
		inject_frame(uart_data_t'(next_rand()), 1'b0, 1'b0);
		repeat (4) next_cycle();
		wait_rx_drain();

		if (exp_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_run("frames were sent but never received");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
sim/tb_uart_top.sv

// File: Bender.yml
package:
  name: uart

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/uart_pkg.sv
      - source/uart_baud_gen.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_uart_top.sv
